// ==== dv/tb_lcd_image_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_lcd_image_gen;

    localparam int GRID_W   = 16;
    localparam int GRID_H   = 12;
    localparam int CELL_PX  = 20;
    localparam int DELAY    = 16;
    localparam int CELLS    = GRID_W * GRID_H;
    localparam int SCAN_CYC = 2 * CELLS + 8;
    localparam int INIT_CYC = 2 * DELAY + 2 * (16 + 2 * CELLS * CELL_PX * CELL_PX) + 16;
    localparam int CELL_CYC = 2 * (11 + 2 * CELL_PX * CELL_PX) + 8;
    // two inits, every cell once plus the single and random cells, some idle scans
    localparam int LIMIT    = 2 * (2 * INIT_CYC + (12 + CELLS) * CELL_CYC + 8 * SCAN_CYC);

    logic       clk = 1'b0;
    logic       nrst;
    logic       head;
    logic       body;
    logic       apple;
    logic       wall;
    logic       game_over;
    logic       start;
    logic [7:0] d;
    logic       dcx;
    logic       wr;
    logic [3:0] x;
    logic [3:0] y;

    // flags per cell as {wall, head, body, apple}
    logic [3:0]  grid [GRID_H][GRID_W];
    // object last drawn on the panel, as the rules predict it
    logic [2:0]  drawn [GRID_H][GRID_W];
    logic [8:0]  exp_q [$];
    logic [31:0] rng = 32'hee44;

    logic [8:0] chk_exp;
    logic [8:0] chk_got;
    logic       chk_valid = 1'b0;
    logic       chk_extra = 1'b0;
    logic       hold_chk = 1'b0;
    int         chk_idx;
    int         byte_cnt = 0;
    int         cycle_cnt = 0;
    int         err_cnt = 0;
    int         err_start;
    int         pass_cnt = 0;
    int         fail_cnt = 0;
    string      test_name = "reset";

    lcd_image_gen #(
        .GRID_W       (GRID_W),
        .GRID_H       (GRID_H),
        .CELL_PX      (CELL_PX),
        .DELAY_CYCLES (DELAY)
    ) UUT (
        .clk       (clk),
        .nrst      (nrst),
        .head      (head),
        .body      (body),
        .apple     (apple),
        .wall      (wall),
        .game_over (game_over),
        .start     (start),
        .d         (d),
        .dcx       (dcx),
        .wr        (wr),
        .x         (x),
        .y         (y)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // game logic model, flags follow the cell under scan
    always @(negedge clk) begin
        {wall, head, body, apple} = grid[y][x];
    end

    // byte monitor, wr and the bus are stable at the falling edge
    always @(negedge clk) begin
        chk_valid = 1'b0;
        chk_extra = 1'b0;
        if (nrst && wr) begin
            chk_got = {dcx, d};
            chk_idx = byte_cnt;
            if (exp_q.size() > 0) begin
                chk_exp   = exp_q.pop_front();
                chk_valid = 1'b1;
            end else begin
                chk_extra = 1'b1;
            end
            byte_cnt = byte_cnt + 1;
        end
    end

    a_byte_match: assert property (@(posedge clk) chk_valid |-> (chk_got == chk_exp))
        else begin
            $display("[ERROR] %s: byte %0d expected dcx=%0b d=%02h, actual dcx=%0b d=%02h",
                test_name, chk_idx, chk_exp[8], chk_exp[7:0], chk_got[8], chk_got[7:0]);
            err_cnt = err_cnt + 1;
        end

    a_no_extra_write: assert property (@(posedge clk) !chk_extra)
        else begin
            $display("%s: the panel got byte %02h at byte %0d although nothing was due",
                test_name, chk_got[7:0], chk_idx);
            err_cnt = err_cnt + 1;
        end

    a_wr_low_in_reset: assert property (@(posedge clk) !nrst |-> !wr)
        else begin
            $display("%s: wr went high while reset was held", test_name);
            err_cnt = err_cnt + 1;
        end

    a_xy_hold: assert property (@(posedge clk) disable iff (!nrst)
        hold_chk |=> ($stable(x) && $stable(y)))
        else begin
            $display("%s: the scan position moved while game over was high", test_name);
            err_cnt = err_cnt + 1;
        end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // wall beats head, head beats body, body beats apple
    function automatic logic [2:0] obj_of(input logic [3:0] f);
        if (f[3]) return 3'd4;
        if (f[2]) return 3'd1;
        if (f[1]) return 3'd2;
        if (f[0]) return 3'd3;
        return 3'd0;
    endfunction

    function automatic logic [15:0] color_of(input logic [2:0] o);
        case (o)
            3'd1: return 16'hF0F8;
            3'd2: return 16'hF800;
            3'd3: return 16'h00F8;
            3'd4: return 16'h0000;
            default: return 16'hE581;
        endcase
    endfunction

    task automatic push_cmd(input logic [7:0] b);
        exp_q.push_back({1'b0, b});
    endtask

    task automatic push_data(input logic [7:0] b);
        exp_q.push_back({1'b1, b});
    endtask

    task automatic push_window(input logic [7:0] cmd, input logic [15:0] lo,
                               input logic [15:0] hi);
        push_cmd(cmd);
        push_data(lo[15:8]);
        push_data(lo[7:0]);
        push_data(hi[15:8]);
        push_data(hi[7:0]);
    endtask

    task automatic push_pixels(input logic [15:0] color, input int count);
        for (int i = 0; i < count; i++) begin
            push_data(color[7:0]);
            push_data(color[15:8]);
        end
    endtask

    task automatic push_init();
        push_cmd(8'h01);
        push_cmd(8'h11);
        push_cmd(8'h3A);
        push_data(8'h55);
        push_cmd(8'h29);
        push_window(8'h2A, 16'd0, 16'(GRID_W * CELL_PX - 1));
        push_window(8'h2B, 16'd0, 16'(GRID_H * CELL_PX - 1));
        push_cmd(8'h2C);
        push_pixels(16'hE581, CELLS * CELL_PX * CELL_PX);
    endtask

    task automatic push_cell(input int cx, input int cy, input logic [2:0] o);
        push_window(8'h2A, 16'(cx * CELL_PX), 16'((cx + 1) * CELL_PX - 1));
        push_window(8'h2B, 16'(cy * CELL_PX), 16'((cy + 1) * CELL_PX - 1));
        push_cmd(8'h2C);
        push_pixels(color_of(o), CELL_PX * CELL_PX);
    endtask

    // the expected update goes in before the game logic changes the cell
    task automatic set_cell(input int cx, input int cy, input logic [3:0] f);
        if (obj_of(f) != drawn[cy][cx]) begin
            push_cell(cx, cy, obj_of(f));
            drawn[cy][cx] = obj_of(f);
        end
        grid[cy][cx] = f;
    endtask

    task automatic pick_cell(output int cx, output int cy);
        rng = xorshift32(rng);
        cx  = int'(rng[7:0]) % GRID_W;
        cy  = int'(rng[15:8]) % GRID_H;
    endtask

    task automatic pick_multi_flags(output logic [3:0] f);
        int a;
        int b;
        rng = xorshift32(rng);
        a = int'(rng[1:0]);
        b = int'(rng[3:2]);
        if (b == a) begin
            b = (a + 1) % 4;
        end
        f    = rng[7:4];
        f[a] = 1'b1;
        f[b] = 1'b1;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_start = err_cnt;
    endtask

    task automatic end_test();
        if (err_cnt == err_start) begin
            pass_cnt = pass_cnt + 1;
            $display("test %s: passed", test_name);
        end else begin
            fail_cnt = fail_cnt + 1;
            $display("test %s: failed with %0d errors", test_name, err_cnt - err_start);
        end
    endtask

    initial begin
        int         cx;
        int         cy;
        logic [3:0] f;
        nrst      = 1'b0;
        head      = 1'b0;
        body      = 1'b0;
        apple     = 1'b0;
        wall      = 1'b0;
        game_over = 1'b0;
        start     = 1'b0;
        for (int r = 0; r < GRID_H; r++) begin
            for (int c = 0; c < GRID_W; c++) begin
                grid[r][c]  = 4'd0;
                drawn[r][c] = 3'd0;
            end
        end

        begin_test("init_sequence");
        push_init();
        repeat (10) @(negedge clk);
        nrst = 1'b1;
        wait_drain();
        end_test();

        begin_test("empty_grid_idle");
        repeat (SCAN_CYC) @(negedge clk);
        end_test();

        begin_test("single_cell");
        for (int k = 0; k < 4; k++) begin
            pick_cell(cx, cy);
            set_cell(cx, cy, 4'b0001 << k);
            wait_drain();
            @(negedge clk);
        end
        repeat (SCAN_CYC) @(negedge clk);
        end_test();

        begin_test("flag_priority");
        for (int k = 0; k < 8; k++) begin
            pick_cell(cx, cy);
            pick_multi_flags(f);
            set_cell(cx, cy, f);
            wait_drain();
            @(negedge clk);
        end
        repeat (SCAN_CYC) @(negedge clk);
        end_test();

        begin_test("game_over_restart");
        game_over = 1'b1;
        repeat (4) @(negedge clk);
        hold_chk = 1'b1;
        // the game keeps changing cells while the scan is frozen
        for (int k = 0; k < 8; k++) begin
            pick_cell(cx, cy);
            rng = xorshift32(rng);
            grid[cy][cx] = rng[3:0];
            @(negedge clk);
        end
        repeat (SCAN_CYC) @(negedge clk);
        hold_chk = 1'b0;
        @(negedge clk);
        // restart wipes the stored map, so every non-empty cell comes back
        push_init();
        for (int r = 0; r < GRID_H; r++) begin
            for (int c = 0; c < GRID_W; c++) begin
                drawn[r][c] = obj_of(grid[r][c]);
                if (drawn[r][c] != 3'd0) begin
                    push_cell(c, r, drawn[r][c]);
                end
            end
        end
        game_over = 1'b0;
        start     = 1'b1;
        repeat (5) @(negedge clk);
        start = 1'b0;
        wait_drain();
        repeat (SCAN_CYC) @(negedge clk);
        end_test();

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
            pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/lcd_pkg.sv
hw/display_ctrl.sv
hw/frame_tracker.sv
hw/update_sequencer.sv
hw/command_gen.sv
hw/lcd_image_gen.sv
dv/tb_lcd_image_gen.sv

// ==== hw/command_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module command_gen #(
    parameter int GRID_W       = 16,
    parameter int GRID_H       = 12,
    parameter int CELL_PX      = 20,
    parameter int DELAY_CYCLES = 60000
) (
    input  logic                clk,
    input  logic                nrst,
    input  lcd_pkg::seq_state_t mode,
    input  logic [3:0]          x,
    input  logic [3:0]          y,
    input  lcd_pkg::obj_t       obj,
    output logic [7:0]          d,
    output logic                dcx,
    output logic                pause,
    output logic                seq_end
);
    import lcd_pkg::*;

    localparam int INIT_BYTES = 2 * GRID_W * GRID_H * CELL_PX * CELL_PX;
    localparam int CELL_BYTES = 2 * CELL_PX * CELL_PX;
    localparam int PIX_W      = $clog2(INIT_BYTES);
    localparam int DLY_W      = $clog2(DELAY_CYCLES + 1);

    // index of the first pixel byte in each sequence
    localparam logic [4:0] INIT_PIX_IDX = 5'd16;
    localparam logic [4:0] CELL_PIX_IDX = 5'd11;

    localparam logic [15:0] COL_END = 16'(GRID_W * CELL_PX - 1);
    localparam logic [15:0] ROW_END = 16'(GRID_H * CELL_PX - 1);

    logic [4:0]       idx;
    logic [PIX_W-1:0] pix_cnt;
    logic [PIX_W-1:0] pix_last;
    logic [DLY_W-1:0] dly_cnt;

    logic is_init;
    logic is_cell;
    logic is_send;
    logic in_pixels;
    logic at_delay;

    logic [15:0] col_start;
    logic [15:0] col_end;
    logic [15:0] row_start;
    logic [15:0] row_end;
    logic [15:0] obj_color;
    logic [15:0] pix_color;
    logic [7:0]  pix_byte;

    assign is_init = (mode == SEQ_SET_INIT) || (mode == SEQ_SEND_INIT);
    assign is_cell = (mode == SEQ_SET_CELL) || (mode == SEQ_SEND_CELL);
    assign is_send = (mode == SEQ_SEND_INIT) || (mode == SEQ_SEND_CELL);

    // SLPOUT and COLMOD each wait out the delay of the command before them
    assign at_delay = is_init && ((idx == 5'd1) || (idx == 5'd2));
    assign pause    = (mode == SEQ_SET_INIT) && at_delay && (dly_cnt != DLY_W'(DELAY_CYCLES));

    assign in_pixels = (is_init && (idx == INIT_PIX_IDX)) || (is_cell && (idx == CELL_PIX_IDX));
    assign pix_last  = is_init ? PIX_W'(INIT_BYTES - 1) : PIX_W'(CELL_BYTES - 1);
    assign seq_end   = in_pixels && (pix_cnt == pix_last);

    assign col_start = 16'(x) * 16'(CELL_PX);
    assign col_end   = col_start + 16'(CELL_PX - 1);
    assign row_start = 16'(y) * 16'(CELL_PX);
    assign row_end   = row_start + 16'(CELL_PX - 1);

    always_comb begin
        case (obj)
            OBJ_HEAD: obj_color = COLOR_HEAD;
            OBJ_BODY: obj_color = COLOR_BODY;
            OBJ_APPLE: obj_color = COLOR_APPLE;
            OBJ_WALL: obj_color = COLOR_WALL;
            default: obj_color = COLOR_EMPTY;
        endcase
    end

    // low byte of each pixel goes first
    assign pix_color = is_init ? COLOR_EMPTY : obj_color;
    assign pix_byte  = pix_cnt[0] ? pix_color[15:8] : pix_color[7:0];

    always_comb begin
        {d, dcx} = {8'h00, 1'b0};
        if (in_pixels) begin
            {d, dcx} = {pix_byte, 1'b1};
        end else if (is_init) begin
            case (idx)
                5'd0: {d, dcx} = {CMD_SWRESET, 1'b0};
                5'd1: {d, dcx} = {CMD_SLPOUT, 1'b0};
                5'd2: {d, dcx} = {CMD_COLMOD, 1'b0};
                5'd3: {d, dcx} = {PIXEL_FORMAT_565, 1'b1};
                5'd4: {d, dcx} = {CMD_DISPON, 1'b0};
                5'd5: {d, dcx} = {CMD_CASET, 1'b0};
                5'd6: {d, dcx} = {8'h00, 1'b1};
                5'd7: {d, dcx} = {8'h00, 1'b1};
                5'd8: {d, dcx} = {COL_END[15:8], 1'b1};
                5'd9: {d, dcx} = {COL_END[7:0], 1'b1};
                5'd10: {d, dcx} = {CMD_PASET, 1'b0};
                5'd11: {d, dcx} = {8'h00, 1'b1};
                5'd12: {d, dcx} = {8'h00, 1'b1};
                5'd13: {d, dcx} = {ROW_END[15:8], 1'b1};
                5'd14: {d, dcx} = {ROW_END[7:0], 1'b1};
                5'd15: {d, dcx} = {CMD_RAMWR, 1'b0};
                default: {d, dcx} = {8'h00, 1'b0};
            endcase
        end else if (is_cell) begin
            case (idx)
                5'd0: {d, dcx} = {CMD_CASET, 1'b0};
                5'd1: {d, dcx} = {col_start[15:8], 1'b1};
                5'd2: {d, dcx} = {col_start[7:0], 1'b1};
                5'd3: {d, dcx} = {col_end[15:8], 1'b1};
                5'd4: {d, dcx} = {col_end[7:0], 1'b1};
                5'd5: {d, dcx} = {CMD_PASET, 1'b0};
                5'd6: {d, dcx} = {row_start[15:8], 1'b1};
                5'd7: {d, dcx} = {row_start[7:0], 1'b1};
                5'd8: {d, dcx} = {row_end[15:8], 1'b1};
                5'd9: {d, dcx} = {row_end[7:0], 1'b1};
                5'd10: {d, dcx} = {CMD_RAMWR, 1'b0};
                default: {d, dcx} = {8'h00, 1'b0};
            endcase
        end
    end

    // counters advance after each SEND, pixel bytes reuse the last index
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            idx     <= 5'd0;
            pix_cnt <= '0;
            dly_cnt <= '0;
        end else if ((mode == SEQ_IDLE) || (mode == SEQ_DONE)) begin
            idx     <= 5'd0;
            pix_cnt <= '0;
            dly_cnt <= '0;
        end else if (pause) begin
            dly_cnt <= dly_cnt + 1'b1;
        end else if (is_send) begin
            dly_cnt <= '0;
            if (in_pixels) begin
                pix_cnt <= pix_cnt + 1'b1;
            end else begin
                idx <= idx + 5'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/display_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module display_ctrl (
    input  logic clk,
    input  logic nrst,
    input  logic start,
    input  logic game_over,
    input  logic diff,
    input  logic cell_done,
    output logic scan_en,
    output logic clear,
    output logic init_req,
    output logic update_req
);
    import lcd_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    logic start_meta;
    logic start_sync;
    logic start_prev;
    logic start_rise;

    // raw button goes through two flops, the third one gives the edge
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            start_meta <= 1'b0;
            start_sync <= 1'b0;
            start_prev <= 1'b0;
        end else begin
            start_meta <= start;
            start_sync <= start_meta;
            start_prev <= start_sync;
        end
    end

    assign start_rise = start_sync & ~start_prev;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= MODE_INIT;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            MODE_INIT: begin
                if (cell_done) begin
                    state_nxt = MODE_SCAN;
                end
            end
            MODE_SCAN: begin
                // game over wins over a pending cell change
                if (game_over) begin
                    state_nxt = MODE_OVER;
                end else if (diff) begin
                    state_nxt = MODE_UPDATE;
                end
            end
            MODE_UPDATE: begin
                if (cell_done) begin
                    state_nxt = MODE_SCAN;
                end
            end
            MODE_OVER: begin
                if (start_rise) begin
                    state_nxt = MODE_INIT;
                end
            end
        endcase
    end

    assign init_req   = (state == MODE_INIT);
    assign update_req = (state == MODE_UPDATE);
    assign scan_en    = (state == MODE_SCAN) && !game_over;
    // map wipe only on the restart edge, x and y hold while game over
    assign clear      = (state == MODE_OVER) && start_rise;

    a_req_onehot: assert property (@(posedge clk) disable iff (!nrst)
        !(init_req && update_req));

    a_scan_only_in_scan: assert property (@(posedge clk) disable iff (!nrst)
        (state != MODE_SCAN) |-> !scan_en);

endmodule

`default_nettype wire

// ==== hw/frame_tracker.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_tracker #(
    parameter int GRID_W = 16,
    parameter int GRID_H = 12
) (
    input  logic           clk,
    input  logic           nrst,
    input  logic           head,
    input  logic           body,
    input  logic           apple,
    input  logic           wall,
    input  logic           scan_en,
    input  logic           clear,
    output logic [3:0]     x,
    output logic [3:0]     y,
    output lcd_pkg::obj_t  obj,
    output logic           diff
);
    import lcd_pkg::*;

    localparam logic [3:0] X_LAST = 4'(GRID_W - 1);
    localparam logic [3:0] Y_LAST = 4'(GRID_H - 1);

    // last drawn object of every cell
    obj_t map_q [GRID_H][GRID_W];
    obj_t stored;

    // wall first, empty last
    always_comb begin
        if (wall) begin
            obj = OBJ_WALL;
        end else if (head) begin
            obj = OBJ_HEAD;
        end else if (body) begin
            obj = OBJ_BODY;
        end else if (apple) begin
            obj = OBJ_APPLE;
        end else begin
            obj = OBJ_EMPTY;
        end
    end

    assign stored = map_q[y][x];
    assign diff   = (obj != stored);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int r = 0; r < GRID_H; r++) begin
                for (int c = 0; c < GRID_W; c++) begin
                    map_q[r][c] <= OBJ_EMPTY;
                end
            end
        end else if (clear) begin
            for (int r = 0; r < GRID_H; r++) begin
                for (int c = 0; c < GRID_W; c++) begin
                    map_q[r][c] <= OBJ_EMPTY;
                end
            end
        end else if (scan_en) begin
            map_q[y][x] <= obj;
        end
    end

    // scan position, held on a changed cell until the update is done
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            x <= 4'd0;
            y <= 4'd0;
        end else if (clear) begin
            x <= 4'd0;
            y <= 4'd0;
        end else if (scan_en && !diff) begin
            if (x == X_LAST) begin
                x <= 4'd0;
                y <= (y == Y_LAST) ? 4'd0 : y + 4'd1;
            end else begin
                x <= x + 4'd1;
            end
        end
    end

    a_x_in_grid: assert property (@(posedge clk) disable iff (!nrst)
        int'(x) < GRID_W);

endmodule

`default_nettype wire

// ==== hw/lcd_image_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module lcd_image_gen #(
    parameter int GRID_W       = 16,
    parameter int GRID_H       = 12,
    parameter int CELL_PX      = 20,
    parameter int DELAY_CYCLES = 60000
) (
    input  logic       clk,
    input  logic       nrst,
    input  logic       head,
    input  logic       body,
    input  logic       apple,
    input  logic       wall,
    input  logic       game_over,
    input  logic       start,
    output logic [7:0] d,
    output logic       dcx,
    output logic       wr,
    output logic [3:0] x,
    output logic [3:0] y
);
    import lcd_pkg::*;

    logic       scan_en;
    logic       clear;
    logic       init_req;
    logic       update_req;
    logic       diff;
    logic       cell_done;
    logic       pause;
    logic       seq_end;
    obj_t       obj;
    seq_state_t mode;

    display_ctrl u_ctrl (
        .clk        (clk),
        .nrst       (nrst),
        .start      (start),
        .game_over  (game_over),
        .diff       (diff),
        .cell_done  (cell_done),
        .scan_en    (scan_en),
        .clear      (clear),
        .init_req   (init_req),
        .update_req (update_req)
    );

    frame_tracker #(
        .GRID_W (GRID_W),
        .GRID_H (GRID_H)
    ) u_tracker (
        .clk     (clk),
        .nrst    (nrst),
        .head    (head),
        .body    (body),
        .apple   (apple),
        .wall    (wall),
        .scan_en (scan_en),
        .clear   (clear),
        .x       (x),
        .y       (y),
        .obj     (obj),
        .diff    (diff)
    );

    update_sequencer u_seq (
        .clk        (clk),
        .nrst       (nrst),
        .init_req   (init_req),
        .update_req (update_req),
        .pause      (pause),
        .seq_end    (seq_end),
        .mode       (mode),
        .wr         (wr),
        .cell_done  (cell_done)
    );

    command_gen #(
        .GRID_W       (GRID_W),
        .GRID_H       (GRID_H),
        .CELL_PX      (CELL_PX),
        .DELAY_CYCLES (DELAY_CYCLES)
    ) u_cmd (
        .clk     (clk),
        .nrst    (nrst),
        .mode    (mode),
        .x       (x),
        .y       (y),
        .obj     (obj),
        .d       (d),
        .dcx     (dcx),
        .pause   (pause),
        .seq_end (seq_end)
    );

endmodule

`default_nettype wire

// ==== hw/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

    // object codes as stored in the cell map
    typedef enum logic [2:0] {
        OBJ_EMPTY = 3'd0,
        OBJ_HEAD  = 3'd1,
        OBJ_BODY  = 3'd2,
        OBJ_APPLE = 3'd3,
        OBJ_WALL  = 3'd4
    } obj_t;

    typedef enum logic [1:0] {
        MODE_INIT   = 2'd0,
        MODE_SCAN   = 2'd1,
        MODE_UPDATE = 2'd2,
        MODE_OVER   = 2'd3
    } ctrl_state_t;

    typedef enum logic [2:0] {
        SEQ_IDLE      = 3'd0,
        SEQ_SET_INIT  = 3'd1,
        SEQ_SET_CELL  = 3'd2,
        SEQ_SEND_INIT = 3'd3,
        SEQ_SEND_CELL = 3'd4,
        SEQ_DONE      = 3'd5
    } seq_state_t;

    // TFT controller opcodes
    typedef enum logic [7:0] {
        CMD_SWRESET = 8'h01,
        CMD_SLPOUT  = 8'h11,
        CMD_COLMOD  = 8'h3A,
        CMD_DISPON  = 8'h29,
        CMD_CASET   = 8'h2A,
        CMD_PASET   = 8'h2B,
        CMD_RAMWR   = 8'h2C
    } cmd_t;

    // RGB565 colors, empty doubles as the background
    localparam logic [15:0] COLOR_HEAD  = 16'hF0F8;
    localparam logic [15:0] COLOR_BODY  = 16'hF800;
    localparam logic [15:0] COLOR_APPLE = 16'h00F8;
    localparam logic [15:0] COLOR_WALL  = 16'h0000;
    localparam logic [15:0] COLOR_EMPTY = 16'hE581;

    localparam logic [7:0] PIXEL_FORMAT_565 = 8'h55;

endpackage

`default_nettype wire

// ==== hw/update_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module update_sequencer (
    input  logic                clk,
    input  logic                nrst,
    input  logic                init_req,
    input  logic                update_req,
    input  logic                pause,
    input  logic                seq_end,
    output lcd_pkg::seq_state_t mode,
    output logic                wr,
    output logic                cell_done
);
    import lcd_pkg::*;

    seq_state_t state;
    seq_state_t state_nxt;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= SEQ_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // one byte is a SET cycle followed by a SEND cycle
    always_comb begin
        state_nxt = state;
        case (state)
            SEQ_IDLE: begin
                if (init_req) begin
                    state_nxt = SEQ_SET_INIT;
                end else if (update_req) begin
                    state_nxt = SEQ_SET_CELL;
                end
            end
            SEQ_SET_INIT: state_nxt = pause ? SEQ_SET_INIT : SEQ_SEND_INIT;
            SEQ_SET_CELL: state_nxt = pause ? SEQ_SET_CELL : SEQ_SEND_CELL;
            SEQ_SEND_INIT: state_nxt = seq_end ? SEQ_DONE : SEQ_SET_INIT;
            SEQ_SEND_CELL: state_nxt = seq_end ? SEQ_DONE : SEQ_SET_CELL;
            SEQ_DONE: state_nxt = SEQ_IDLE;
            default: state_nxt = SEQ_IDLE;
        endcase
    end

    assign mode      = state;
    assign wr        = (state == SEQ_SEND_INIT) || (state == SEQ_SEND_CELL);
    assign cell_done = (state == SEQ_DONE);

    a_wr_single: assert property (@(posedge clk) disable iff (!nrst)
        wr |=> !wr);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, then search the log for failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_lcd_image_gen \
    --Mdir obj_dir -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or simulation stopped with an error, see build.log and sim.log"; exit 1; }

grep -q "=== FAIL ===" sim.log \
    && { echo "simulation reported failures, see sim.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
